/* verilog/dnc_retention_macros.svh */
// Fixed-point widths, unity constant, size limits and index widths
`ifndef DNC_RETENTION_MACROS_SVH
`define DNC_RETENTION_MACROS_SVH

// Data word, unsigned Q1.15
`define DNC_DATA_W 16
`define DNC_FRAC   15

// Fixed-point one
`define DNC_ONE 16'h8000

// Largest supported head count and location count
`define DNC_MAX_R 4
`define DNC_MAX_N 16

// Index widths for heads and locations
`define DNC_I_W 2
`define DNC_J_W 4

// Weight RAM address, row i then column j
`define DNC_ADDR_W 6

`endif

/* verilog/dnc_retention_pkg.sv */
// Package with the host command opcodes and the retention engine states
package dnc_retention_pkg;

  //////////////////////////////////////////////////////////////
  // Host commands
  //////////////////////////////////////////////////////////////

  // index_i = R-1, index_j = N-1 for OP_SET_SIZE
  typedef enum logic [1:0] {
    OP_SET_SIZE = 2'd0,
    OP_WRITE_F  = 2'd1,
    OP_WRITE_W  = 2'd2,
    OP_START    = 2'd3
  } cmd_op_t;

  //////////////////////////////////////////////////////////////
  // Engine FSM
  //////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_FETCH = 3'd1,
    ST_TERM  = 3'd2,
    ST_ACCUM = 3'd3,
    ST_EMIT  = 3'd4
  } engine_state_t;

endpackage

/* verilog/dnc_weight_memory.sv */
// Single-port weight RAM with registered read data
`timescale 1ns/1ps
`include "dnc_retention_macros.svh"

module dnc_weight_memory (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   en,
  input  logic                   we,
  input  logic [`DNC_ADDR_W-1:0] addr,
  input  logic [15:0]            wdata,
  output logic [15:0]            rdata
);

  // One word per (head, location) pair
  logic [`DNC_DATA_W-1:0] mem [0:`DNC_MAX_R*`DNC_MAX_N-1];

  // Write port
  always_ff @(posedge CLK) begin
    if (en && we) begin
      mem[addr] <= wdata;
    end
  end

  // Read port, one cycle latency
  // Output register holds last read word between accesses
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rdata <= '0;
    end else if (en && !we) begin
      rdata <= mem[addr];
    end
  end

endmodule

/* verilog/dnc_memory_arbiter.sv */
// Fixed-priority arbiter sharing the weight RAM between host writes and engine reads
`timescale 1ns/1ps
`include "dnc_retention_macros.svh"

module dnc_memory_arbiter (
  input  logic                   CLK,
  input  logic                   RST,
  // Host side, write only
  input  logic                   wr_req,
  input  logic [`DNC_ADDR_W-1:0] wr_addr,
  input  logic [15:0]            wr_data,
  // Engine side, read only
  input  logic                   rd_req,
  input  logic [`DNC_ADDR_W-1:0] rd_addr,
  output logic                   rd_valid,
  output logic [15:0]            rd_data,
  // RAM port
  output logic                   mem_en,
  output logic                   mem_we,
  output logic [`DNC_ADDR_W-1:0] mem_addr,
  output logic [15:0]            mem_wdata,
  input  logic [15:0]            mem_rdata
);

  // Read wins only in a cycle with no write
  logic rd_grant;

  assign rd_grant = rd_req && !wr_req;

  //////////////////////////////////////////////////////////////
  // RAM port mux
  //////////////////////////////////////////////////////////////

  assign mem_en    = wr_req || rd_grant;
  assign mem_we    = wr_req;
  assign mem_addr  = wr_req ? wr_addr : rd_addr;
  assign mem_wdata = wr_data;

  // Grant delayed by RAM latency
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_grant;
    end
  end

  // RAM output register drives read data directly
  assign rd_data = mem_rdata;

endmodule

/* verilog/dnc_host_port.sv */
// Host command decoder with size and free-gate registers, RAM writes and start pulse
`timescale 1ns/1ps
`include "dnc_retention_macros.svh"

module dnc_host_port (
  input  logic                                  CLK,
  input  logic                                  RST,
  // Command strobe from host
  input  logic                                  cmd_strobe,
  input  dnc_retention_pkg::cmd_op_t            cmd_op,
  input  logic [`DNC_I_W-1:0]                   cmd_index_i,
  input  logic [`DNC_J_W-1:0]                   cmd_index_j,
  input  logic [15:0]                           cmd_data,
  // Configuration to engine
  output logic [`DNC_I_W:0]                     size_r,
  output logic [`DNC_J_W:0]                     size_n,
  output logic [`DNC_MAX_R*`DNC_DATA_W-1:0]     f_gates,
  output logic                                  start,
  // Write request to arbiter
  output logic                                  wr_req,
  output logic [`DNC_ADDR_W-1:0]                wr_addr,
  output logic [15:0]                           wr_data
);

  import dnc_retention_pkg::*;

  //////////////////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_r  <= '0;
      size_n  <= '0;
      f_gates <= '0;
      start   <= 1'b0;
      wr_req  <= 1'b0;
      wr_addr <= '0;
      wr_data <= '0;
    end else begin
      // Pulses last one cycle
      start  <= 1'b0;
      wr_req <= 1'b0;
      if (cmd_strobe) begin
        case (cmd_op)
          // Host sends R-1 and N-1
          OP_SET_SIZE: begin
            size_r <= {1'b0, cmd_index_i} + 1'b1;
            size_n <= {1'b0, cmd_index_j} + 1'b1;
          end
          OP_WRITE_F: begin
            f_gates[cmd_index_i*`DNC_DATA_W +: `DNC_DATA_W] <= cmd_data;
          end
          // Row i, column j, so address is i*MAX_N + j
          OP_WRITE_W: begin
            wr_req  <= 1'b1;
            wr_addr <= {cmd_index_i, cmd_index_j};
            wr_data <= cmd_data;
          end
          OP_START: begin
            start <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

/* verilog/dnc_memory_retention_vector.sv */
// Retention engine FSM with multiply, subtract and product-accumulate datapath
`timescale 1ns/1ps
`include "dnc_retention_macros.svh"

module dnc_memory_retention_vector (
  input  logic                              CLK,
  input  logic                              RST,
  // Control and configuration
  input  logic                              start,
  input  logic [`DNC_I_W:0]                 size_r,
  input  logic [`DNC_J_W:0]                 size_n,
  input  logic [`DNC_MAX_R*`DNC_DATA_W-1:0] f_gates,
  // Read port through arbiter
  output logic                              rd_req,
  output logic [`DNC_ADDR_W-1:0]            rd_addr,
  input  logic                              rd_valid,
  input  logic [15:0]                       rd_data,
  // Result stream
  output logic                              busy,
  output logic                              psi_strobe,
  output logic [`DNC_J_W-1:0]               psi_index,
  output logic [15:0]                       psi_data,
  output logic                              done
);

  import dnc_retention_pkg::*;

  // psi(j) = prod over i of (ONE - f(i)*w(i,j))

  engine_state_t state;

  // Loop counters and latched bounds
  logic [`DNC_I_W-1:0] i_cnt;
  logic [`DNC_J_W-1:0] j_cnt;
  logic [`DNC_I_W-1:0] last_i;
  logic [`DNC_J_W-1:0] last_j;

  // Sizes minus one, zero size treated as one
  logic [`DNC_I_W:0] r_last;
  logic [`DNC_J_W:0] n_last;

  // Datapath registers
  logic [`DNC_DATA_W-1:0] w_q;
  logic [`DNC_DATA_W-1:0] term_q;
  logic [`DNC_DATA_W-1:0] acc_q;

  // Full-width products
  logic [`DNC_DATA_W-1:0]   f_sel;
  logic [2*`DNC_DATA_W-1:0] fw_prod;
  logic [2*`DNC_DATA_W-1:0] acc_prod;

  assign r_last = (size_r == '0) ? '0 : size_r - 1'b1;
  assign n_last = (size_n == '0) ? '0 : size_n - 1'b1;

  //////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////

  assign f_sel    = f_gates[i_cnt*`DNC_DATA_W +: `DNC_DATA_W];
  assign fw_prod  = f_sel * w_q;
  assign acc_prod = acc_q * term_q;

  // Address is i*MAX_N + j
  assign rd_addr = {i_cnt, j_cnt};

  // Request held through FETCH, dropped once data returns
  assign rd_req = (state == ST_FETCH) && !rd_valid;

  // Result outputs
  assign busy       = (state != ST_IDLE);
  assign psi_strobe = (state == ST_EMIT);
  assign psi_index  = j_cnt;
  assign psi_data   = acc_q;
  assign done       = (state == ST_EMIT) && (j_cnt == last_j);

  //////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= ST_IDLE;
      i_cnt  <= '0;
      j_cnt  <= '0;
      last_i <= '0;
      last_j <= '0;
      w_q    <= '0;
      term_q <= '0;
      acc_q  <= '0;
    end else begin
      case (state)
        // Start ignored unless idle, sizes captured here
        ST_IDLE: begin
          if (start) begin
            last_i <= r_last[`DNC_I_W-1:0];
            last_j <= n_last[`DNC_J_W-1:0];
            i_cnt  <= '0;
            j_cnt  <= '0;
            acc_q  <= `DNC_ONE;
            state  <= ST_FETCH;
          end
        end
        // Wait for w(i,j), host writes stall here
        ST_FETCH: begin
          if (rd_valid) begin
            w_q   <= rd_data;
            state <= ST_TERM;
          end
        end
        // ONE - (f*w >> 15), truncated
        ST_TERM: begin
          term_q <= `DNC_ONE - fw_prod[`DNC_FRAC +: `DNC_DATA_W];
          state  <= ST_ACCUM;
        end
        // Running product times term
        ST_ACCUM: begin
          acc_q <= acc_prod[`DNC_FRAC +: `DNC_DATA_W];
          if (i_cnt == last_i) begin
            state <= ST_EMIT;
          end else begin
            i_cnt <= i_cnt + 1'b1;
            state <= ST_FETCH;
          end
        end
        // Column finished, strobe out
        ST_EMIT: begin
          if (j_cnt == last_j) begin
            state <= ST_IDLE;
          end else begin
            j_cnt <= j_cnt + 1'b1;
            i_cnt <= '0;
            acc_q <= `DNC_ONE;
            state <= ST_FETCH;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* verilog/dnc_retention_top.sv */
// Top level joining host port, retention engine, arbiter and weight RAM
`timescale 1ns/1ps
`include "dnc_retention_macros.svh"

module dnc_retention_top (
  input  logic                       CLK,
  input  logic                       RST,
  // Host command port
  input  logic                       cmd_strobe,
  input  dnc_retention_pkg::cmd_op_t cmd_op,
  input  logic [`DNC_I_W-1:0]        cmd_index_i,
  input  logic [`DNC_J_W-1:0]        cmd_index_j,
  input  logic [15:0]                cmd_data,
  // Status and result stream
  output logic                       busy,
  output logic                       psi_strobe,
  output logic [`DNC_J_W-1:0]        psi_index,
  output logic [15:0]                psi_data,
  output logic                       done
);

  //////////////////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////////////////

  // Configuration
  logic [`DNC_I_W:0]                 size_r;
  logic [`DNC_J_W:0]                 size_n;
  logic [`DNC_MAX_R*`DNC_DATA_W-1:0] f_gates;
  logic                              start;

  // Host write path
  logic                              wr_req;
  logic [`DNC_ADDR_W-1:0]            wr_addr;
  logic [15:0]                       wr_data;

  // Engine read path
  logic                              rd_req;
  logic [`DNC_ADDR_W-1:0]            rd_addr;
  logic                              rd_valid;
  logic [15:0]                       rd_data;

  // RAM port
  logic                              mem_en;
  logic                              mem_we;
  logic [`DNC_ADDR_W-1:0]            mem_addr;
  logic [15:0]                       mem_wdata;
  logic [15:0]                       mem_rdata;

  dnc_host_port u_host_port (
    .CLK(CLK), .RST(RST),
    .cmd_strobe(cmd_strobe), .cmd_op(cmd_op),
    .cmd_index_i(cmd_index_i), .cmd_index_j(cmd_index_j), .cmd_data(cmd_data),
    .size_r(size_r), .size_n(size_n), .f_gates(f_gates), .start(start),
    .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  dnc_memory_retention_vector u_engine (
    .CLK(CLK), .RST(RST),
    .start(start), .size_r(size_r), .size_n(size_n), .f_gates(f_gates),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_data(rd_data),
    .busy(busy), .psi_strobe(psi_strobe), .psi_index(psi_index),
    .psi_data(psi_data), .done(done)
  );

  // Host writes have priority
  dnc_memory_arbiter u_arbiter (
    .CLK(CLK), .RST(RST),
    .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_data(rd_data),
    .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  dnc_weight_memory u_memory (
    .CLK(CLK), .RST(RST),
    .en(mem_en), .we(mem_we), .addr(mem_addr),
    .wdata(mem_wdata), .rdata(mem_rdata)
  );

endmodule

/* dv/dnc_retention_assertions.sv */
// Concurrent protocol checks bound onto the retention top level
`timescale 1ns/1ps

module dnc_retention_assertions (
  input logic                             CLK,
  input logic                             RST,
  input logic                             busy,
  input logic                             psi_strobe,
  input logic                             done,
  input logic                             wr_req,
  input logic                             rd_valid,
  input dnc_retention_pkg::engine_state_t engine_state
);

  import dnc_retention_pkg::*;

  // Count of failed properties
  int fail_cnt;

  initial fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // Status and result stream
  ////////////////////////////////////////////////////////////

  // Quiet outputs while reset held
  reset_quiet: assert property (@(posedge CLK) RST |-> (!busy && !done))
    else begin
      fail_cnt++;
      $error("busy or done high during reset");
    end

  // Last column strobe carries done
  done_has_psi: assert property (@(posedge CLK) disable iff (RST) done |-> psi_strobe)
    else begin
      fail_cnt++;
      $error("done without psi_strobe");
    end

  psi_while_busy: assert property (@(posedge CLK) disable iff (RST) psi_strobe |-> busy)
    else begin
      fail_cnt++;
      $error("psi_strobe while engine idle");
    end

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  // Read valid is the registered grant, so none after a write cycle
  no_grant_on_write: assert property (@(posedge CLK) disable iff (RST)
    wr_req |=> !rd_valid)
    else begin
      fail_cnt++;
      $error("engine read granted in a host write cycle");
    end

  // Read data returns only to a waiting fetch
  rd_valid_in_fetch: assert property (@(posedge CLK) disable iff (RST)
    rd_valid |-> (engine_state == ST_FETCH))
    else begin
      fail_cnt++;
      $error("read data returned outside ST_FETCH");
    end

endmodule

/* dv/dnc_retention_tb.sv */
// Testbench with clock, reset, file-driven command player, psi checker, LFSR gaps and watchdog
`timescale 1ns/1ps
`include "dnc_retention_macros.svh"

module dnc_retention_tb;

  import dnc_retention_pkg::*;

  // Record store depth and watchdog budget
  localparam int MAX_RECS       = 256;
  localparam int CYCLES_PER_REC = 200;

  logic                CLK;
  logic                RST;
  logic                cmd_strobe;
  cmd_op_t             cmd_op;
  logic [`DNC_I_W-1:0] cmd_index_i;
  logic [`DNC_J_W-1:0] cmd_index_j;
  logic [15:0]         cmd_data;
  logic                busy;
  logic                psi_strobe;
  logic [`DNC_J_W-1:0] psi_index;
  logic [15:0]         psi_data;
  logic                done;

  // Records as type, i, j, data
  logic [27:0] recs [0:MAX_RECS-1];
  int          rec_total;
  int          err_cnt;
  int          strobe_cnt;
  int          done_cnt;
  int          exp_cnt;
  logic [15:0] lfsr_q;
  // Expected psi, {j, value}
  logic [19:0] exp_q [$];

  dnc_retention_top dut (
    .CLK(CLK), .RST(RST),
    .cmd_strobe(cmd_strobe), .cmd_op(cmd_op),
    .cmd_index_i(cmd_index_i), .cmd_index_j(cmd_index_j), .cmd_data(cmd_data),
    .busy(busy), .psi_strobe(psi_strobe), .psi_index(psi_index),
    .psi_data(psi_data), .done(done)
  );

  bind dnc_retention_top dnc_retention_assertions u_assertions (
    .CLK(CLK), .RST(RST), .busy(busy), .psi_strobe(psi_strobe), .done(done),
    .wr_req(wr_req), .rd_valid(rd_valid), .engine_state(u_engine.state)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Random idle gaps
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // 0 to 3 idle cycles, one LFSR step per bit
  task automatic idle_gap();
    logic [1:0] gap;
    for (int k = 0; k < 2; k++) begin
      gap    = {gap[0], lfsr_q[15]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    repeat (gap) @(negedge CLK);
  endtask

  ////////////////////////////////////////////////////////////
  // Command player
  ////////////////////////////////////////////////////////////

  // Called just after a falling edge, strobe held for one cycle
  task automatic issue_cmd(input cmd_op_t op, input logic [27:0] rec);
    cmd_strobe  = 1'b1;
    cmd_op      = op;
    cmd_index_i = rec[21:20];
    cmd_index_j = rec[19:16];
    cmd_data    = rec[15:0];
    @(negedge CLK);
    cmd_strobe = 1'b0;
    idle_gap();
  endtask

  // Wait for done, then check strobe and done counts of the run
  task automatic finish_run();
    int waited;
    waited = 0;
    while (done_cnt == 0 && waited < 4000) begin
      @(negedge CLK);
      waited++;
    end
    // Room for a stray second run to show
    repeat (4) @(negedge CLK);
    assert (done_cnt == 1) else begin
      err_cnt++;
      $display("Expected one done strobe in the run, saw %0d", done_cnt);
    end
    assert (strobe_cnt == exp_cnt) else begin
      err_cnt++;
      $display("Expected %0d psi strobes in the run, saw %0d", exp_cnt, strobe_cnt);
    end
    assert (!busy) else begin
      err_cnt++;
      $display("Engine still busy after the run ended");
    end
    done_cnt   = 0;
    strobe_cnt = 0;
    exp_cnt    = 0;
    exp_q.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // psi checker, sampled on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    logic [19:0] exp_rec;
    if (!RST && psi_strobe) begin
      strobe_cnt++;
      assert (exp_q.size() > 0) else begin
        err_cnt++;
        $display("Unexpected psi strobe at index %0d", psi_index);
      end
      if (exp_q.size() > 0) begin
        exp_rec = exp_q.pop_front();
        assert (psi_index == exp_rec[19:16]) else begin
          err_cnt++;
          $display("Mismatch psi_index: expected 0x%h, actual 0x%h", exp_rec[19:16], psi_index);
        end
        assert (psi_data == exp_rec[15:0]) else begin
          err_cnt++;
          $display("Mismatch psi_data at j=%0d: expected 0x%h, actual 0x%h",
                   exp_rec[19:16], exp_rec[15:0], psi_data);
        end
      end
      if (done) begin
        done_cnt++;
        assert (exp_q.size() == 0) else begin
          err_cnt++;
          $display("done strobe arrived before the last expected column");
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [27:0] rec;
    logic        stop;
    int          cnt;
    cmd_strobe  = 1'b0;
    cmd_op      = OP_SET_SIZE;
    cmd_index_i = '0;
    cmd_index_j = '0;
    cmd_data    = '0;
    RST         = 1'b0;
    err_cnt     = 0;
    strobe_cnt  = 0;
    done_cnt    = 0;
    exp_cnt     = 0;
    lfsr_q      = 16'd88;
    stop        = 1'b0;
    cnt         = 0;
    $readmemh("dv/retention_cases.txt", recs);
    while (cnt < MAX_RECS && recs[cnt][27:24] !== 4'hF) begin
      cnt++;
    end
    rec_total = cnt;
    #10 RST = 1'b1;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    for (int idx = 0; idx < rec_total && !stop; idx++) begin
      rec = recs[idx];
      case (rec[27:24])
        4'h0: issue_cmd(OP_SET_SIZE, rec);
        4'h1: issue_cmd(OP_WRITE_F, rec);
        4'h2: issue_cmd(OP_WRITE_W, rec);
        4'h3: issue_cmd(OP_START, rec);
        4'h4: begin
          exp_q.push_back(rec[19:0]);
          exp_cnt++;
        end
        4'h5: finish_run();
        default: begin
          err_cnt++;
          $display("Unreadable record at entry %0d of the case file", idx);
          stop = 1'b1;
        end
      endcase
    end
    err_cnt += dut.u_assertions.fail_cnt;
    $display("Run complete with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog, budget scales with the number of records
  initial begin
    wait (rec_total > 0);
    repeat (rec_total * CYCLES_PER_REC) @(posedge CLK);
    $display("Timeout after %0d clock cycles", rec_total * CYCLES_PER_REC);
    $display("sim failed");
    $finish;
  end

endmodule

/* retention.f */
+incdir+verilog
verilog/dnc_retention_pkg.sv
verilog/dnc_weight_memory.sv
verilog/dnc_memory_arbiter.sv
verilog/dnc_host_port.sv
verilog/dnc_memory_retention_vector.sv
verilog/dnc_retention_top.sv
dv/dnc_retention_assertions.sv
dv/dnc_retention_tb.sv

/* dv/retention_cases.txt */
// One record per hex word, type_i_j_data; types 0 size (i=R-1, j=N-1), 1 f, 2 w, 3 start
// 4 expected psi (j, value), 5 end of run, F end of file
// Run A, sizes left at reset, f = w = ONE
1_0_0_8000 2_0_0_8000 3_0_0_0000 4_0_0_0000 5_0_0_0000
// Run B, explicit 1x1, f = 0
0_0_0_0000 1_0_0_0000 3_0_0_0000 4_0_0_8000 5_0_0_0000
// Run C, 4x16 with free gates 1.0, 0.5, 0.75, 0.25
0_3_F_0000 1_0_0_8000 1_1_0_4000 1_2_0_6000 1_3_0_2000
// Row 0
2_0_0_0000 2_0_1_8000 2_0_2_4000 2_0_3_0000 2_0_4_0000 2_0_5_0000 2_0_6_4000 2_0_7_0000
2_0_8_0003 2_0_9_0000 2_0_A_0000 2_0_B_8000 2_0_C_0000 2_0_D_2000 2_0_E_7FFF 2_0_F_8000
// Row 1
2_1_0_0000 2_1_1_0000 2_1_2_0000 2_1_3_8000 2_1_4_0000 2_1_5_0000 2_1_6_4000 2_1_7_0000
2_1_8_0003 2_1_9_0000 2_1_A_1235 2_1_B_1000 2_1_C_0000 2_1_D_2000 2_1_E_0000 2_1_F_8000
// Row 2
2_2_0_0000 2_2_1_0000 2_2_2_0000 2_2_3_0000 2_2_4_8000 2_2_5_0000 2_2_6_0000 2_2_7_0001
2_2_8_0005 2_2_9_0000 2_2_A_0000 2_2_B_0000 2_2_C_5555 2_2_D_2000 2_2_E_0000 2_2_F_8000
// Row 3
2_3_0_0000 2_3_1_0000 2_3_2_0000 2_3_3_0000 2_3_4_0000 2_3_5_8000 2_3_6_0000 2_3_7_0000
2_3_8_0007 2_3_9_7FFF 2_3_A_0000 2_3_B_0000 2_3_C_4000 2_3_D_2000 2_3_E_0000 2_3_F_8000
3_0_0_0000
4_0_0_8000 4_0_1_0000 4_0_2_4000 4_0_3_4000 4_0_4_2000 4_0_5_6000 4_0_6_3000 4_0_7_8000
4_0_8_7FF8 4_0_9_6001 4_0_A_76E6 4_0_B_0000 4_0_C_3800 4_0_D_3FFC 4_0_E_0001 4_0_F_0000
// Same weights rewritten mid-run, plus a second start while busy
2_1_A_1235 2_0_8_0003 2_3_9_7FFF 3_0_0_0000 2_2_C_5555 2_0_D_2000
5_0_0_0000
// Run D, R = 2 and N = 5 over the same memory
0_1_4_0000 3_0_0_0000 4_0_0_8000 4_0_1_0000 4_0_2_4000 4_0_3_4000 4_0_4_8000 5_0_0_0000
F_0_0_0000
